// File: rs_dec.f
+incdir+include
design/rs_pkg.sv
design/rs_syndrome_count.sv
design/rs_frame_buffer.sv
design/rs_peterson_solver.sv
design/rs_chien_forney.sv
design/rs_dec.sv
testbench/tb_rs_dec.sv

// File: run_sim.sh
#!/bin/sh
# build and run the rs_dec testbench with verilator

cd "$(dirname "$0")" || exit 1

echo "building simulation"
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
  --top-module tb_rs_dec -f rs_dec.f -o sim_rs_dec
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

echo "running simulation"
output=$(./obj_dir/sim_rs_dec)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "Everything OK"; then
  exit 0
fi
echo "pass line not found in simulation output"
exit 1

// File: include/tb_rs_model.svh
`ifndef TB_RS_MODEL_SVH
`define TB_RS_MODEL_SVH

  //----------------------------------------------------------------------
  // reference model of the RS(15,11) code
  //----------------------------------------------------------------------

  // symbol i sits in bits [4*i +: 4], symbol 0 is sent first
  typedef logic [rs_pkg::n*rs_pkg::m-1:0] frame_t;

  // shift and add multiply, reduced by x^4 + x + 1
  function automatic rs_pkg::gf_t field_mul(input rs_pkg::gf_t a, input rs_pkg::gf_t b);
    rs_pkg::gf_t p;
    rs_pkg::gf_t x;
    p = '0;
    x = a;
    for (int k = 0; k < 4; k++) begin
      if (b[k])
        p = p ^ x;
      x = {x[2:0], 1'b0} ^ (x[3] ? 4'h3 : 4'h0);
    end
    return p;
  endfunction

  function automatic rs_pkg::gf_t alpha_power(input int e);
    rs_pkg::gf_t r;
    r = 4'h1;
    for (int k = 0; k < e % 15; k++)
      r = field_mul(r, 4'h2);
    return r;
  endfunction

  function automatic int count_bits(input frame_t v);
    int c;
    c = 0;
    for (int i = 0; i < $bits(frame_t); i++)
      c += int'(v[i]);
    return c;
  endfunction

  function automatic int count_symbol_diffs(input frame_t a, input frame_t b);
    int c;
    c = 0;
    for (int i = 0; i < rs_pkg::n; i++)
      if (a[4*i +: 4] != b[4*i +: 4])
        c++;
    return c;
  endfunction

  // random data in symbols 0..10, parity left at zero
  function automatic frame_t random_message();
    frame_t f;
    f = '0;
    for (int i = 0; i < rs_pkg::n - rs_pkg::check; i++)
      f[4*i +: 4] = 4'($urandom);
    return f;
  endfunction

  // systematic encoder, parity = m(x) * x^4 mod g(x)
  function automatic frame_t encode_frame(input frame_t msg);
    rs_pkg::gf_t g   [5];
    rs_pkg::gf_t par [4];
    rs_pkg::gf_t fb;
    frame_t      cw;
    for (int k = 0; k < 5; k++)
      g[k] = (k == 0) ? 4'h1 : 4'h0;
    // g(x) = (x + a^0)(x + a^1)(x + a^2)(x + a^3)
    for (int j = 0; j < rs_pkg::check; j++) begin
      for (int k = 4; k > 0; k--)
        g[k] = g[k-1] ^ field_mul(g[k], alpha_power(j));
      g[0] = field_mul(g[0], alpha_power(j));
    end
    for (int k = 0; k < 4; k++)
      par[k] = '0;
    cw = msg;
    // division lfsr, highest power first
    for (int i = 0; i < rs_pkg::n - rs_pkg::check; i++) begin
      fb = cw[4*i +: 4] ^ par[3];
      for (int k = 3; k > 0; k--)
        par[k] = par[k-1] ^ field_mul(fb, g[k]);
      par[0] = field_mul(fb, g[0]);
    end
    for (int q = 0; q < rs_pkg::check; q++)
      cw[4*(rs_pkg::n - rs_pkg::check + q) +: 4] = par[3-q];
    return cw;
  endfunction

  // all four syndromes zero, roots a^0..a^3
  function automatic logic is_codeword(input frame_t f);
    rs_pkg::gf_t s;
    for (int j = 0; j < rs_pkg::check; j++) begin
      s = '0;
      for (int i = 0; i < rs_pkg::n; i++)
        s = field_mul(s, alpha_power(j)) ^ f[4*i +: 4];
      if (s != '0)
        return 1'b0;
    end
    return 1'b1;
  endfunction

  // nerr distinct positions, each hit by a non-zero value
  function automatic frame_t inject_errors(input frame_t cw, input int nerr, output int nbits);
    frame_t               rx;
    logic [rs_pkg::n-1:0] used;
    int                   p;
    rs_pkg::gf_t          v;
    rx    = cw;
    used  = '0;
    nbits = 0;
    for (int e = 0; e < nerr; e++) begin
      p = int'($urandom % rs_pkg::n);
      // step on to the next free position
      while (used[p])
        p = (p + 1) % rs_pkg::n;
      used[p] = 1'b1;
      v = 4'($urandom % 15 + 1);
      rx[4*p +: 4] = rx[4*p +: 4] ^ v;
      nbits += count_bits(frame_t'(v));
    end
    return rx;
  endfunction

`endif

// File: testbench/tb_rs_dec.sv
`timescale 1ns/100ps

module tb_rs_dec;

  logic                         iclk;
  logic                         ireset;
  logic                         iclkena;
  logic                         isop;
  logic                         ival;
  logic                         ieop;
  rs_pkg::gf_t                  idat;
  logic                         osop;
  logic                         oval;
  logic                         oeop;
  logic                         odecfail;
  rs_pkg::gf_t                  odat;
  logic [rs_pkg::sym_err_w-1:0] onum_err_sym;
  logic [rs_pkg::bit_err_w-1:0] onum_err_bit;

  `include "tb_rs_model.svh"

  // one frame in flight as sent and as encoded
  typedef struct packed {
    frame_t     rx;
    frame_t     orig;
    logic [2:0] nerr;
    logic [4:0] nbits;
  } sb_entry_t;

  sb_entry_t   sb [$];
  // enabled-cycle count at each accepted ieop
  int          stamp_q [$];
  int          errors;
  int          frames_checked;
  int          tests_run;
  int          en_cnt;
  int          sym_cnt;
  frame_t      out_frame;
  logic        out_seen;
  logic        timed_out;
  logic        ena_random;

  rs_dec rs_dec_i (.*);

  initial begin
    iclk = 1'b0;
    forever #5 iclk = ~iclk;
  end

  // enable drawn at the edge and driven 1 ns later
  initial begin : clock_enable
    logic next_ena;
    iclkena = 1'b1;
    forever begin
      @(posedge iclk);
      next_ena = ena_random ? (($urandom % 4) != 0) : 1'b1;
      #1;
      iclkena = next_ena;
    end
  end

  //----------------------------------------------------------------------
  // protocol checks
  //----------------------------------------------------------------------

  idle_before_output: assert property (@(posedge iclk) disable iff (ireset)
    (!out_seen && !osop) |->
      !(oval || oeop || odecfail || onum_err_sym != 0 || onum_err_bit != 0))
  else begin
    $display("output active before the first frame came out");
    errors++;
  end

  // outputs only move on enabled edges
  oval_needs_enable: assert property (@(posedge iclk) disable iff (ireset)
    $rose(oval) |-> $past(iclkena))
  else begin
    $display("oval rose after a cycle with iclkena low");
    errors++;
  end

  framing_inside_oval: assert property (@(posedge iclk) disable iff (ireset)
    (osop || oeop) |-> oval)
  else begin
    $display("osop or oeop seen without oval");
    errors++;
  end

  //----------------------------------------------------------------------
  // frame checks
  //----------------------------------------------------------------------

  task automatic compare_frame(input frame_t got, input frame_t exp);
    for (int i = 0; i < rs_pkg::n; i++) begin
      assert (got[4*i +: 4] == exp[4*i +: 4]) else begin
        $display("** Error: odat[%0d] = %h, expected %h", i, got[4*i +: 4], exp[4*i +: 4]);
        errors++;
      end
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    assert (got == exp) else begin
      $display("** Error: %s = %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_frame(input frame_t got, input int nsym);
    sb_entry_t e;
    if (sb.size() == 0) begin
      $display("output frame arrived with no frame outstanding");
      errors++;
      return;
    end
    e = sb.pop_front();
    frames_checked++;
    if (nsym != rs_pkg::n) begin
      $display("output frame had %0d symbols instead of 15", nsym);
      errors++;
    end
    if (e.nerr <= 3'd2) begin
      // expect the original codeword back when within reach
      compare_frame(got, e.orig);
      check_count("odecfail", int'(odecfail), 0);
      check_count("onum_err_sym", int'(onum_err_sym), int'(e.nerr));
      check_count("onum_err_bit", int'(onum_err_bit), int'(e.nbits));
    end else if (odecfail) begin
      // failure passes the received frame through
      compare_frame(got, e.rx);
      check_count("onum_err_sym", int'(onum_err_sym), 0);
      check_count("onum_err_bit", int'(onum_err_bit), 0);
    end else begin
      // miscorrection still has to land on a codeword
      assert (is_codeword(got)) else begin
        $display("frame without decode failure is not a codeword");
        errors++;
      end
      assert (onum_err_sym <= 2'd2) else begin
        $display("** Error: onum_err_sym = %h, expected at most %h", onum_err_sym, 2);
        errors++;
      end
      check_count("onum_err_sym", int'(onum_err_sym), count_symbol_diffs(got, e.rx));
      check_count("onum_err_bit", int'(onum_err_bit), count_bits(got ^ e.rx));
    end
  endtask

  // output monitor sampling on enabled edges only
  always @(posedge iclk) begin
    if (!ireset) begin
      if (iclkena && ival && ieop)
        stamp_q.push_back(en_cnt);
      if (iclkena && oval) begin
        if (osop) begin
          out_seen = 1'b1;
          sym_cnt  = 0;
          if (stamp_q.size() == 0) begin
            $display("osop seen with no frame end accepted before it");
            errors++;
          end else begin
            check_count("osop latency", en_cnt - stamp_q[0], 5);
            stamp_q.delete(0);
          end
        end
        if (sym_cnt < rs_pkg::n)
          out_frame[4*sym_cnt +: 4] = odat;
        sym_cnt++;
        if (oeop)
          check_frame(out_frame, sym_cnt);
      end
      if (iclkena)
        en_cnt++;
    end
  end

  //----------------------------------------------------------------------
  // stimulus
  //----------------------------------------------------------------------

  // hold the symbol until an enabled edge takes it
  task automatic drive_symbol(input logic sop, input logic eop, input rs_pkg::gf_t dat);
    int   waited;
    logic taken;
    isop  = sop;
    ieop  = eop;
    ival  = 1'b1;
    idat  = dat;
    taken = 1'b0;
    for (waited = 0; waited < 100 && !taken; waited++) begin
      @(posedge iclk);
      taken = iclkena;
      #1;
    end
    if (!taken) begin
      $display("input symbol not accepted within 100 cycles");
      errors++;
      timed_out = 1'b1;
    end
  endtask

  task automatic send_frame(input int nerr);
    sb_entry_t e;
    int        nbits;
    if (timed_out)
      return;
    e.orig  = encode_frame(random_message());
    e.rx    = inject_errors(e.orig, nerr, nbits);
    e.nerr  = 3'(nerr);
    e.nbits = 5'(nbits);
    sb.push_back(e);
    for (int i = 0; i < rs_pkg::n && !timed_out; i++)
      drive_symbol(i == 0, i == rs_pkg::n - 1, e.rx[4*i +: 4]);
    isop = 1'b0;
    ival = 1'b0;
    ieop = 1'b0;
  endtask

  task automatic wait_drain();
    int waited;
    if (timed_out)
      return;
    for (waited = 0; waited < 1000 && sb.size() != 0; waited++) begin
      @(posedge iclk);
      #1;
    end
    if (sb.size() != 0) begin
      $display("%0d frames still missing after 1000 cycles", sb.size());
      errors++;
      timed_out = 1'b1;
    end
  endtask

  task automatic report_test(input string name, input int err_mark, input int frame_mark);
    tests_run++;
    $display("test %-14s frames %0d, errors %0d", name, frames_checked - frame_mark,
             errors - err_mark);
  endtask

  // back to back frames with min_err..max_err injected errors each
  task automatic run_frames(input string name, input int count, input int min_err,
                            input int max_err);
    int err_mark;
    int frame_mark;
    err_mark   = errors;
    frame_mark = frames_checked;
    for (int f = 0; f < count; f++)
      send_frame(min_err + int'($urandom % (max_err - min_err + 1)));
    wait_drain();
    report_test(name, err_mark, frame_mark);
  endtask

  initial begin : main
    int err_mark;
    int frame_mark;
    void'($urandom(32'h3c2c));
    errors         = 0;
    frames_checked = 0;
    tests_run      = 0;
    en_cnt         = 0;
    sym_cnt        = 0;
    out_frame      = '0;
    out_seen       = 1'b0;
    timed_out      = 1'b0;
    ena_random     = 1'b0;
    ireset         = 1'b1;
    isop           = 1'b0;
    ival           = 1'b0;
    ieop           = 1'b0;
    idat           = '0;
    repeat (8) @(posedge iclk);
    #1;
    ireset = 1'b0;

    // quiet period after reset watched by idle_before_output
    err_mark   = errors;
    frame_mark = frames_checked;
    repeat (20) @(posedge iclk);
    #1;
    report_test("reset idle", err_mark, frame_mark);

    run_frames("clean", 4, 0, 0);
    run_frames("one or two", 10, 1, 2);
    run_frames("three to five", 10, 3, 5);
    ena_random = 1'b1;
    run_frames("random enable", 16, 0, 2);
    ena_random = 1'b0;

    $display("tests %0d, frames checked %0d, errors %0d", tests_run, frames_checked, errors);
    if (errors == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

endmodule

// File: design/rs_dec.sv
`timescale 1ns/100ps

module rs_dec (
  input  logic                         iclk,
  input  logic                         ireset,
  input  logic                         iclkena,
  input  logic                         isop,
  input  logic                         ival,
  input  logic                         ieop,
  input  rs_pkg::gf_t                  idat,
  output logic                         osop,
  output logic                         oval,
  output logic                         oeop,
  output logic                         odecfail,
  output rs_pkg::gf_t                  odat,
  output logic [rs_pkg::sym_err_w-1:0] onum_err_sym,
  output logic [rs_pkg::bit_err_w-1:0] onum_err_bit
);

  // input side to buffer
  logic              sc_write;
  rs_pkg::ptr_t      sc_wptr;
  rs_pkg::addr_t     sc_waddr;

  // syndromes to solver, locator to corrector
  rs_pkg::syndrome_t syndrome;
  rs_pkg::locator_t  locator;

  // corrector to buffer and back
  logic              cf_rread;
  rs_pkg::ptr_t      cf_rptr;
  rs_pkg::addr_t     cf_raddr;
  rs_pkg::gf_t       buf_rdata;

  //----------------------------------------------------------------------
  // branch 1, syndromes and error locator
  //----------------------------------------------------------------------

  rs_syndrome_count syndrome_count (
    .iclk     (iclk),
    .ireset   (ireset),
    .iclkena  (iclkena),
    .isop     (isop),
    .ival     (ival),
    .ieop     (ieop),
    .idat     (idat),
    .write    (sc_write),
    .wptr     (sc_wptr),
    .waddr    (sc_waddr),
    .syndrome (syndrome)
  );

  rs_peterson_solver solver (
    .iclk     (iclk),
    .ireset   (ireset),
    .iclkena  (iclkena),
    .syndrome (syndrome),
    .locator  (locator)
  );

  //----------------------------------------------------------------------
  // branch 2, frame storage
  //----------------------------------------------------------------------

  // page pointer travels with the syndromes to keep the branches aligned
  rs_frame_buffer frame_buffer (
    .iclk    (iclk),
    .iclkena (iclkena),
    .write   (sc_write),
    .wptr    (sc_wptr),
    .waddr   (sc_waddr),
    .wdata   (idat),
    .rread   (cf_rread),
    .rptr    (cf_rptr),
    .raddr   (cf_raddr),
    .rdata   (buf_rdata)
  );

  // root search and correction
  rs_chien_forney chien_forney (
    .iclk         (iclk),
    .ireset       (ireset),
    .iclkena      (iclkena),
    .locator      (locator),
    .rread        (cf_rread),
    .rptr         (cf_rptr),
    .raddr        (cf_raddr),
    .rdata        (buf_rdata),
    .osop         (osop),
    .oval         (oval),
    .oeop         (oeop),
    .odat         (odat),
    .odecfail     (odecfail),
    .onum_err_sym (onum_err_sym),
    .onum_err_bit (onum_err_bit)
  );

endmodule

// File: design/rs_chien_forney.sv
`timescale 1ns/100ps

module rs_chien_forney (
  input  logic                         iclk,
  input  logic                         ireset,
  input  logic                         iclkena,
  input  rs_pkg::locator_t             locator,
  // buffer read port
  output logic                         rread,
  output rs_pkg::ptr_t                 rptr,
  output rs_pkg::addr_t                raddr,
  input  rs_pkg::gf_t                  rdata,
  // corrected stream and status
  output logic                         osop,
  output logic                         oval,
  output logic                         oeop,
  output rs_pkg::gf_t                  odat,
  output logic                         odecfail,
  output logic [rs_pkg::sym_err_w-1:0] onum_err_sym,
  output logic [rs_pkg::bit_err_w-1:0] onum_err_bit
);

  // read sequencer
  logic          rd_run;
  rs_pkg::addr_t rd_cnt;
  rs_pkg::ptr_t  rd_ptr;

  // symbol on its way out of the buffer
  logic          sy_val;
  logic          sy_sop;
  logic          sy_eop;
  rs_pkg::addr_t sy_idx;

  // root search over the whole frame, done when the locator arrives
  logic [rs_pkg::n-1:0]         root_mask;
  logic [$clog2(rs_pkg::n+1)-1:0] root_cnt;

  // per-frame values
  logic [rs_pkg::n-1:0]         fr_root;
  logic                         fr_fail;
  logic [rs_pkg::sym_err_w-1:0] fr_nsym;
  rs_pkg::gf_t                  fr_omega0;
  rs_pkg::gf_t                  fr_omega1;
  rs_pkg::gf_t                  fr_inv_l1;

  // per-symbol correction
  rs_pkg::gf_t                  mag;
  rs_pkg::gf_t                  fix;
  logic [rs_pkg::bit_err_w-1:0] bit_acc;
  logic [rs_pkg::bit_err_w-1:0] bit_nxt;

  //----------------------------------------------------------------------
  // buffer read, index 0 goes out in the locator cycle
  //----------------------------------------------------------------------

  assign rread = locator.val | rd_run;
  assign rptr  = locator.val ? locator.ptr : rd_ptr;
  assign raddr = locator.val ? '0 : rd_cnt;

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      rd_run <= 1'b0;
      rd_cnt <= '0;
      sy_val <= 1'b0;
      sy_sop <= 1'b0;
      sy_eop <= 1'b0;
    end else if (iclkena) begin
      sy_val <= rread;
      sy_sop <= locator.val;
      sy_eop <= rd_run && (rd_cnt == rs_pkg::n - 1);
      if (locator.val) begin
        rd_run <= 1'b1;
        rd_cnt <= 4'd1;
      end else if (rd_run) begin
        rd_run <= (rd_cnt != rs_pkg::n - 1);
        rd_cnt <= rd_cnt + 1'b1;
      end
    end
  end

  //----------------------------------------------------------------------
  // chien search, all positions in parallel
  //----------------------------------------------------------------------

  // index i sits at power n-1-i, so X^-1 = alpha^(i+1)
  always_comb begin : chien
    rs_pkg::gf_t x_inv;
    rs_pkg::gf_t ev;
    root_cnt = '0;
    for (int i = 0; i < rs_pkg::n; i++) begin
      x_inv = rs_pkg::gf_pow_alpha(4'(i + 1));
      ev    = 4'd1 ^ rs_pkg::gf_mul(locator.lambda1, x_inv) ^
              rs_pkg::gf_mul(locator.lambda2, rs_pkg::gf_mul(x_inv, x_inv));
      root_mask[i] = (ev == '0);
      root_cnt     = root_cnt + root_mask[i];
    end
  end

  // latch the frame, fail if the root count disagrees with the degree
  always_ff @(posedge iclk) begin
    if (iclkena && locator.val) begin
      rd_ptr    <= locator.ptr;
      fr_root   <= root_mask;
      fr_fail   <= locator.decfail | (root_cnt != locator.deg);
      fr_nsym   <= root_cnt[rs_pkg::sym_err_w-1:0];
      fr_omega0 <= locator.omega0;
      fr_omega1 <= locator.omega1;
      // lambda'(x) is just lambda1 in char 2
      fr_inv_l1 <= rs_pkg::gf_inv(locator.lambda1);
    end
  end

  //----------------------------------------------------------------------
  // forney, e = X^(1-genstart) * omega(X^-1) / lambda'(X^-1)
  //----------------------------------------------------------------------

  always_ff @(posedge iclk) begin
    if (iclkena)
      sy_idx <= raddr;
  end

  always_comb begin : forney
    rs_pkg::gf_t x_pos;
    x_pos = rs_pkg::gf_pow_alpha(4'(rs_pkg::n - 1 - sy_idx));
    // genstart 0: X * (omega0 + omega1/X) = omega0*X + omega1
    mag = rs_pkg::gf_mul(rs_pkg::gf_mul(fr_omega0, x_pos) ^ fr_omega1, fr_inv_l1);
    // failed frames pass through untouched
    fix = (fr_root[sy_idx] && !fr_fail) ? mag : '0;
    bit_nxt = (sy_sop ? '0 : bit_acc) + fix[0] + fix[1] + fix[2] + fix[3];
  end

  //----------------------------------------------------------------------
  // output stream and status
  //----------------------------------------------------------------------

  always_ff @(posedge iclk) begin
    if (iclkena) begin
      odat <= rdata ^ fix;
      if (sy_val)
        bit_acc <= bit_nxt;
    end
  end

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      osop         <= 1'b0;
      oval         <= 1'b0;
      oeop         <= 1'b0;
      odecfail     <= 1'b0;
      onum_err_sym <= '0;
      onum_err_bit <= '0;
    end else if (iclkena) begin
      osop <= sy_sop;
      oval <= sy_val;
      oeop <= sy_eop;
      // status valid with oeop, held until the next one
      if (sy_eop) begin
        odecfail     <= fr_fail;
        onum_err_sym <= fr_fail ? '0 : fr_nsym;
        onum_err_bit <= bit_nxt;
      end
    end
  end

endmodule

// File: design/rs_peterson_solver.sv
`timescale 1ns/100ps

module rs_peterson_solver (
  input  logic              iclk,
  input  logic              ireset,
  input  logic              iclkena,
  input  rs_pkg::syndrome_t syndrome,
  output rs_pkg::locator_t  locator
);

  // stage 1 results
  logic         st_val;
  rs_pkg::ptr_t st_ptr;
  rs_pkg::gf_t  st_s1;
  rs_pkg::gf_t  st_s2;
  rs_pkg::gf_t  st_det;
  rs_pkg::gf_t  st_num1;
  rs_pkg::gf_t  st_num2;
  logic         st_zero;

  // stage 2 candidates
  rs_pkg::gf_t      inv_det;
  rs_pkg::gf_t      l1_two;
  rs_pkg::gf_t      l2_two;
  rs_pkg::gf_t      l1_one;
  logic             one_ok;
  rs_pkg::locator_t loc_nxt;

  //----------------------------------------------------------------------
  // stage 1, determinant terms of the 2x2 system
  //----------------------------------------------------------------------

  // s3 + l1*s2 + l2*s1 = 0
  // s4 + l1*s3 + l2*s2 = 0
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset)
      st_val <= 1'b0;
    else if (iclkena)
      st_val <= syndrome.val;
  end

  always_ff @(posedge iclk) begin
    if (iclkena && syndrome.val) begin
      st_ptr  <= syndrome.ptr;
      st_s1   <= syndrome.s1;
      st_s2   <= syndrome.s2;
      // cramer terms, char 2 so every minus is an xor
      st_det  <= rs_pkg::gf_mul(syndrome.s2, syndrome.s2) ^
                 rs_pkg::gf_mul(syndrome.s1, syndrome.s3);
      st_num1 <= rs_pkg::gf_mul(syndrome.s2, syndrome.s3) ^
                 rs_pkg::gf_mul(syndrome.s1, syndrome.s4);
      st_num2 <= rs_pkg::gf_mul(syndrome.s2, syndrome.s4) ^
                 rs_pkg::gf_mul(syndrome.s3, syndrome.s3);
      st_zero <= (syndrome.s1 | syndrome.s2 | syndrome.s3 | syndrome.s4) == '0;
    end
  end

  //----------------------------------------------------------------------
  // stage 2, pick the degree and form locator and evaluator
  //----------------------------------------------------------------------

  always_comb begin
    inv_det = rs_pkg::gf_inv(st_det);
    l1_two  = rs_pkg::gf_mul(st_num1, inv_det);
    l2_two  = rs_pkg::gf_mul(st_num2, inv_det);
    // single error: s2/s1 = X, and the next ratio must agree
    l1_one  = rs_pkg::gf_mul(st_s2, rs_pkg::gf_inv(st_s1));
    one_ok  = (st_s1 != '0) && (st_s2 != '0) && (st_num2 == '0);

    loc_nxt     = '0;
    loc_nxt.val = st_val;
    loc_nxt.ptr = st_ptr;
    if (st_zero) begin
      // clean frame, degree 0
      loc_nxt.deg = 2'd0;
    end else if (st_det != '0) begin
      loc_nxt.lambda1 = l1_two;
      loc_nxt.lambda2 = l2_two;
      loc_nxt.deg     = 2'd2;
    end else if (one_ok) begin
      loc_nxt.lambda1 = l1_one;
      loc_nxt.deg     = 2'd1;
    end else begin
      loc_nxt.decfail = 1'b1;
    end

    // omega = s(x) * lambda(x) mod x^2
    if (!loc_nxt.decfail) begin
      loc_nxt.omega0 = st_s1;
      loc_nxt.omega1 = st_s2 ^ rs_pkg::gf_mul(loc_nxt.lambda1, st_s1);
    end
  end

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset)
      locator <= '0;
    else if (iclkena)
      locator <= loc_nxt;
  end

endmodule

// File: design/rs_frame_buffer.sv
`timescale 1ns/100ps

module rs_frame_buffer (
  input  logic          iclk,
  input  logic          iclkena,
  // write side, driven by the input stream
  input  logic          write,
  input  rs_pkg::ptr_t  wptr,
  input  rs_pkg::addr_t waddr,
  input  rs_pkg::gf_t   wdata,
  // read side, driven by the corrector
  input  logic          rread,
  input  rs_pkg::ptr_t  rptr,
  input  rs_pkg::addr_t raddr,
  output rs_pkg::gf_t   rdata
);

  //----------------------------------------------------------------------
  // two pages of one frame each
  //----------------------------------------------------------------------

  // one page fills while the other drains
  rs_pkg::gf_t mem [2][rs_pkg::n];

  always_ff @(posedge iclk) begin
    if (iclkena && write)
      mem[wptr][waddr] <= wdata;
  end

  // registered read port, data one enabled cycle after rread
  // a same-address write in that cycle returns the old symbol
  always_ff @(posedge iclk) begin
    if (iclkena && rread)
      rdata <= mem[rptr][raddr];
  end

endmodule

// File: design/rs_syndrome_count.sv
`timescale 1ns/100ps

module rs_syndrome_count (
  input  logic              iclk,
  input  logic              ireset,
  input  logic              iclkena,
  input  logic              isop,
  input  logic              ival,
  input  logic              ieop,
  input  rs_pkg::gf_t       idat,
  output logic              write,
  output rs_pkg::ptr_t      wptr,
  output rs_pkg::addr_t     waddr,
  output rs_pkg::syndrome_t syndrome
);

  // symbol index of the next symbol, page of the frame being received
  rs_pkg::addr_t idx;
  rs_pkg::ptr_t  page;

  // horner accumulators, one per syndrome
  rs_pkg::gf_t   acc     [rs_pkg::check];
  rs_pkg::gf_t   acc_nxt [rs_pkg::check];

  //----------------------------------------------------------------------
  // buffer write side
  //----------------------------------------------------------------------

  // isop forces index 0 even if the previous frame was cut short
  assign write = ival;
  assign wptr  = page;
  assign waddr = isop ? '0 : idx;

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      idx  <= '0;
      page <= 1'b0;
    end else if (iclkena && ival) begin
      idx <= ieop ? '0 : waddr + 1'b1;
      // next frame goes to the other page
      if (ieop)
        page <= ~page;
    end
  end

  //----------------------------------------------------------------------
  // horner evaluation, symbol 0 is the highest power
  //----------------------------------------------------------------------

  always_comb begin : horner
    rs_pkg::gf_t prod;
    for (int j = 0; j < rs_pkg::check; j++) begin
      // acc * alpha^(genstart + j) as a chain of constant shifts
      prod = acc[j];
      for (int k = 0; k < rs_pkg::genstart + j; k++) begin
        prod = rs_pkg::gf_xtime(prod);
      end
      // first symbol of a frame restarts the sum
      acc_nxt[j] = (isop ? '0 : prod) ^ idat;
    end
  end

  always_ff @(posedge iclk) begin
    if (iclkena && ival)
      acc <= acc_nxt;
  end

  // publish at the end of the frame, tagged with its page
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      syndrome <= '0;
    end else if (iclkena) begin
      syndrome.val <= ival & ieop;
      if (ival && ieop) begin
        syndrome.ptr <= page;
        syndrome.s1  <= acc_nxt[0];
        syndrome.s2  <= acc_nxt[1];
        syndrome.s3  <= acc_nxt[2];
        syndrome.s4  <= acc_nxt[3];
      end
    end
  end

endmodule

// File: design/rs_pkg.sv
package rs_pkg;

  //----------------------------------------------------------------------
  // code and field constants, RS(15,11) over GF(16)
  //----------------------------------------------------------------------

  localparam int m         = 4;
  localparam int n         = 15;
  localparam int check     = 4;
  localparam int t         = 2;
  localparam int irrpol    = 19;
  localparam int genstart  = 0;
  localparam int sym_err_w = 2;
  localparam int bit_err_w = 4;

  `include "rs_gf_tables.svh"

  // one field element / symbol
  typedef logic [m-1:0]            gf_t;
  // symbol index inside a frame
  typedef logic [$clog2(n)-1:0]    addr_t;
  // buffer page
  typedef logic                    ptr_t;

  //----------------------------------------------------------------------
  // pipeline records
  //----------------------------------------------------------------------

  // syndromes s1..s4 are r(alpha^genstart) .. r(alpha^(genstart+3))
  typedef struct packed {
    logic val;
    ptr_t ptr;
    gf_t  s1;
    gf_t  s2;
    gf_t  s3;
    gf_t  s4;
  } syndrome_t;

  // locator 1 + lambda1*x + lambda2*x^2, evaluator omega0 + omega1*x
  typedef struct packed {
    logic                   val;
    ptr_t                   ptr;
    gf_t                    lambda1;
    gf_t                    lambda2;
    gf_t                    omega0;
    gf_t                    omega1;
    logic [$clog2(t+1)-1:0] deg;
    logic                   decfail;
  } locator_t;

  //----------------------------------------------------------------------
  // field arithmetic
  //----------------------------------------------------------------------

  // log/antilog multiply, log sum folded back into 0..15
  function automatic gf_t gf_mul(input gf_t a, input gf_t b);
    logic [m:0] s;
    s = log_table[a] + log_table[b];
    if (s > 5'd15)
      s = s - 5'd15;
    return ((a == '0) || (b == '0)) ? '0 : exp_table[s[m-1:0]];
  endfunction

  // inverse is alpha^(15 - log a); zero maps to zero
  function automatic gf_t gf_inv(input gf_t a);
    logic [m-1:0] e;
    e = 4'(15 - log_table[a]);
    return (a == '0) ? '0 : exp_table[e];
  endfunction

  function automatic gf_t gf_pow_alpha(input logic [m-1:0] e);
    return exp_table[e];
  endfunction

  // multiply by alpha: shift, then reduce by the field polynomial
  function automatic gf_t gf_xtime(input gf_t a);
    return {a[m-2:0], 1'b0} ^ (a[m-1] ? gf_t'(irrpol) : '0);
  endfunction

endpackage

// File: include/rs_gf_tables.svh
`ifndef RS_GF_TABLES_SVH
`define RS_GF_TABLES_SVH

  //----------------------------------------------------------------------
  // GF(16) tables for the field polynomial x^4 + x + 1
  //----------------------------------------------------------------------

  // alpha^i for i = 0..15
  // entry 15 wraps back to alpha^0 so exponents 0..15 need no modulo
  localparam logic [3:0] exp_table [0:15] = '{
    4'd1,  4'd2,  4'd4,  4'd8,
    4'd3,  4'd6,  4'd12, 4'd11,
    4'd5,  4'd10, 4'd7,  4'd14,
    4'd15, 4'd13, 4'd9,  4'd1
  };

  // discrete log of each element
  // entry 0 has no log, callers test for a zero operand first
  localparam logic [3:0] log_table [0:15] = '{
    4'd0,  4'd0,  4'd1,  4'd4,
    4'd2,  4'd8,  4'd5,  4'd10,
    4'd3,  4'd14, 4'd9,  4'd7,
    4'd6,  4'd13, 4'd11, 4'd12
  };

`endif
